//--- vip_stream_pkg.sv
package vip_stream_pkg;

	////////////////////////////////////////////////////////////
	// Beat format on the streaming interfaces
	////////////////////////////////////////////////////////////

	localparam int bits_per_symbol = 8;
	localparam int symbols_per_beat = 3;

	// Symbol 0 sits in the low bits of the beat.
	typedef logic [symbols_per_beat-1:0][bits_per_symbol-1:0] beat_t;

	////////////////////////////////////////////////////////////
	// Packet type codes
	////////////////////////////////////////////////////////////

	// Carried in the low nibble of symbol 0 of the header beat.
	localparam logic [3:0] type_video = 4'd0;
	localparam logic [3:0] type_ctrl = 4'd15;

	////////////////////////////////////////////////////////////
	// Frame geometry used until the first control packet
	////////////////////////////////////////////////////////////

	localparam logic [15:0] width_default = 16'd640;
	localparam logic [15:0] height_default = 16'd480;
	localparam logic [3:0] interlaced_default = 4'd0;

endpackage

//--- vip_ctrl_pkg.sv
package vip_ctrl_pkg;

	////////////////////////////////////////////////////////////
	// Control packet contents
	////////////////////////////////////////////////////////////

	// Width is the most significant field, so the nibble order on the
	// wire matches the packed bit order of the struct.
	typedef struct packed {
		logic [15:0] width;
		logic [15:0] height;
		logic [3:0] interlaced;
	} ctrl_fields_t;

	// Width nibbles 3..0, height nibbles 3..0, then interlaced.
	// One nibble rides in the low bits of each symbol.
	localparam int ctrl_nibbles = 9;

endpackage

//--- vip_core_if.sv
`timescale 1ns/1ns

interface vip_core_if #(
	parameter int BEAT_W = 24
) ();

	// Beat and control fields moving towards the sink.
	logic [BEAT_W-1:0] data;
	vip_ctrl_pkg::ctrl_fields_t ctrl;
	logic ctrl_valid;
	logic write;
	logic end_of_video;

	// Back-pressure from the sink.
	logic stall;

	modport source (
		output data,
		output ctrl,
		output ctrl_valid,
		output write,
		output end_of_video,
		input stall
	);

	modport sink (
		input data,
		input ctrl,
		input ctrl_valid,
		input write,
		input end_of_video,
		output stall
	);

endinterface

//--- vip_packet_decoder.sv
`timescale 1ns/1ns

module vip_packet_decoder (
	input logic clk,
	input logic rst,
	input logic din_valid,
	input logic din_sop,
	input logic din_eop,
	input vip_stream_pkg::beat_t din_data,
	output logic din_ready,
	vip_core_if.source core
);

	localparam int nib_w = 4 * vip_ctrl_pkg::ctrl_nibbles;
	localparam int cnt_w = $clog2(vip_ctrl_pkg::ctrl_nibbles + 1);

	logic accept;
	logic hdr_video;
	logic hdr_ctrl;
	logic in_video;
	logic in_ctrl;
	logic pend_write;
	logic pend_ctrl;
	logic payload_ctrl;
	logic [nib_w-1:0] nib_sr;
	logic [nib_w-1:0] nib_sr_next;
	logic [cnt_w-1:0] nib_cnt;
	logic [cnt_w-1:0] nib_cnt_next;
	vip_stream_pkg::beat_t data_q;
	logic eov_q;
	vip_ctrl_pkg::ctrl_fields_t ctrl_q;

	assign din_ready = ~core.stall;
	assign accept = din_valid & din_ready;
	assign hdr_video = din_data[0][3:0] == vip_stream_pkg::type_video;
	assign hdr_ctrl = din_data[0][3:0] == vip_stream_pkg::type_ctrl;
	assign payload_ctrl = accept & ~din_sop & in_ctrl;

	// Shift in one nibble per symbol, symbol 0 first, until the packet is full.
	always_comb begin
		nib_sr_next = nib_sr;
		nib_cnt_next = nib_cnt;
		for (int s = 0; s < vip_stream_pkg::symbols_per_beat; s++) begin
			if (nib_cnt_next < vip_ctrl_pkg::ctrl_nibbles) begin
				nib_sr_next = {nib_sr_next[nib_w-5:0], din_data[s][3:0]};
				nib_cnt_next = nib_cnt_next + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Packet tracking and output strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			in_video <= 1'b0;
			in_ctrl <= 1'b0;
			nib_cnt <= '0;
			pend_write <= 1'b0;
			pend_ctrl <= 1'b0;
		end else begin
			// A held item leaves as soon as stall drops.
			if (!core.stall) begin
				pend_write <= accept & ~din_sop & in_video;
				pend_ctrl <= payload_ctrl & din_eop &
					(nib_cnt_next == vip_ctrl_pkg::ctrl_nibbles);
			end
			if (accept) begin
				if (din_sop) begin
					in_video <= hdr_video & ~din_eop;
					in_ctrl <= hdr_ctrl & ~din_eop;
					nib_cnt <= '0;
				end else begin
					if (din_eop) begin
						in_video <= 1'b0;
						in_ctrl <= 1'b0;
					end
					if (in_ctrl) begin
						nib_cnt <= nib_cnt_next;
					end
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			data_q <= din_data;
			eov_q <= din_eop;
		end
		if (payload_ctrl) begin
			nib_sr <= nib_sr_next;
		end
		if (payload_ctrl && din_eop) begin
			ctrl_q <= vip_ctrl_pkg::ctrl_fields_t'(nib_sr_next);
		end
	end

	assign core.data = data_q;
	assign core.end_of_video = eov_q;
	assign core.ctrl = ctrl_q;
	assign core.write = pend_write & ~core.stall;
	assign core.ctrl_valid = pend_ctrl & ~core.stall;

	// A write held back by stall keeps its beat until the core takes it.
	a_hold_in_stall: assert property (@(posedge clk) disable iff (rst)
		pend_write && core.stall |=> pend_write && $stable(core.data));

endmodule

//--- vip_symbol_swap_core.sv
`timescale 1ns/1ns

module vip_symbol_swap_core #(
	parameter int BITS_PER_SYMBOL = 8,
	parameter int SYMBOLS_PER_BEAT = 3
) (
	input logic clk,
	input logic rst,
	vip_core_if.sink core_in,
	vip_core_if.source core_out
);

	localparam int beat_w = BITS_PER_SYMBOL * SYMBOLS_PER_BEAT;

	logic [beat_w-1:0] swapped;
	logic [beat_w-1:0] data_q;
	logic wr_q;
	logic ctrl_valid_q;
	logic eov_q;
	vip_ctrl_pkg::ctrl_fields_t ctrl_q;

	// The whole chain stalls together.
	assign core_in.stall = core_out.stall;

	// First symbol goes last, e.g. RGB becomes BGR.
	always_comb begin
		for (int s = 0; s < SYMBOLS_PER_BEAT; s++) begin
			swapped[s*BITS_PER_SYMBOL +: BITS_PER_SYMBOL] =
				core_in.data[(SYMBOLS_PER_BEAT-1-s)*BITS_PER_SYMBOL +: BITS_PER_SYMBOL];
		end
	end

	////////////////////////////////////////////////////////////
	// Pipeline register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_q <= 1'b0;
			ctrl_valid_q <= 1'b0;
		end else if (!core_out.stall) begin
			wr_q <= core_in.write;
			ctrl_valid_q <= core_in.ctrl_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (core_in.write) begin
			data_q <= swapped;
			eov_q <= core_in.end_of_video;
		end
		if (core_in.ctrl_valid) begin
			ctrl_q <= core_in.ctrl;
		end
	end

	// Held item is released in the first cycle without stall.
	assign core_out.write = wr_q & ~core_out.stall;
	assign core_out.ctrl_valid = ctrl_valid_q & ~core_out.stall;
	assign core_out.data = data_q;
	assign core_out.end_of_video = eov_q;
	assign core_out.ctrl = ctrl_q;

endmodule

//--- vip_flow_control_output.sv
`timescale 1ns/1ns

module vip_flow_control_output #(
	parameter int BITS_PER_SYMBOL = 8,
	parameter int SYMBOLS_PER_BEAT = 3,
	parameter logic [15:0] WIDTH_DEFAULT = 16'd640,
	parameter logic [15:0] HEIGHT_DEFAULT = 16'd480,
	parameter logic [3:0] INTERLACED_DEFAULT = 4'd0
) (
	input logic clk,
	input logic rst,
	vip_core_if.sink core,
	input logic dout_ready,
	input logic ctrl_busy,
	output logic dout_valid,
	output logic dout_end_of_video,
	output logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] dout_data,
	output logic ctrl_send,
	output vip_ctrl_pkg::ctrl_fields_t enc_ctrl
);

	vip_ctrl_pkg::ctrl_fields_t ctrl_held;
	logic ctrl_pending;

	////////////////////////////////////////////////////////////
	// Write/stall to valid/ready
	////////////////////////////////////////////////////////////

	assign dout_valid = core.write;
	assign dout_data = core.data;
	assign dout_end_of_video = core.end_of_video;
	assign core.stall = ~dout_ready;

	////////////////////////////////////////////////////////////
	// Control values towards the encoder
	////////////////////////////////////////////////////////////

	// Live fields win in the cycle they arrive.
	assign enc_ctrl = core.ctrl_valid ? core.ctrl : ctrl_held;
	assign ctrl_send = (ctrl_pending | core.ctrl_valid) & ~ctrl_busy;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ctrl_held.width <= WIDTH_DEFAULT;
			ctrl_held.height <= HEIGHT_DEFAULT;
			ctrl_held.interlaced <= INTERLACED_DEFAULT;
			ctrl_pending <= 1'b0;
		end else begin
			ctrl_held <= enc_ctrl;
			// An update during a busy encoder waits here.
			if (core.ctrl_valid || !ctrl_busy) begin
				ctrl_pending <= core.ctrl_valid & ctrl_busy;
			end
		end
	end

	// Every send is taken up by the encoder on the next cycle.
	a_send_taken: assert property (@(posedge clk) disable iff (rst)
		ctrl_send |=> ctrl_busy);

endmodule

//--- vip_packet_encoder.sv
`timescale 1ns/1ns

module vip_packet_encoder #(
	parameter int BITS_PER_SYMBOL = 8,
	parameter int SYMBOLS_PER_BEAT = 3
) (
	input logic clk,
	input logic rst,
	input logic dout_valid_in,
	input logic dout_end_of_video,
	input logic ctrl_send,
	input logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] beat_in,
	input vip_ctrl_pkg::ctrl_fields_t enc_ctrl,
	output logic ctrl_busy,
	output logic ready_out,
	output logic dout_valid,
	output logic dout_sop,
	output logic dout_eop,
	output logic [BITS_PER_SYMBOL*SYMBOLS_PER_BEAT-1:0] dout_data,
	input logic dout_ready
);

	localparam int beat_w = BITS_PER_SYMBOL * SYMBOLS_PER_BEAT;
	localparam int nibbles = vip_ctrl_pkg::ctrl_nibbles;
	localparam int ctrl_beats = (nibbles + SYMBOLS_PER_BEAT - 1) / SYMBOLS_PER_BEAT;
	localparam int cnt_w = $clog2(ctrl_beats + 1);
	localparam logic [beat_w-1:0] hdr_ctrl = {{(beat_w-4){1'b0}}, vip_stream_pkg::type_ctrl};
	localparam logic [beat_w-1:0] hdr_video = {{(beat_w-4){1'b0}}, vip_stream_pkg::type_video};

	typedef enum logic [2:0] {
		st_idle,
		st_ctrl_hdr,
		st_ctrl_pay,
		st_vid_hdr,
		st_vid_body
	} state_t;

	state_t state;
	logic [cnt_w-1:0] beat_cnt;
	vip_ctrl_pkg::ctrl_fields_t ctrl_q;
	logic [beat_w-1:0] ctrl_beat;
	logic [beat_w-1:0] pix_q;
	logic pix_held;
	logic pix_eov;
	logic out_free;
	logic take_in;
	logic load;
	logic [beat_w-1:0] load_data;
	logic load_sop;
	logic load_eop;

	assign out_free = ~dout_valid | dout_ready;
	assign take_in = dout_valid_in & ready_out;
	assign ctrl_busy = (state != st_idle) | dout_valid;

	// Pixels wait in the core while a header or control beat is due.
	always_comb begin
		case (state)
			st_idle: ready_out = out_free & ~pix_held;
			st_vid_body: ready_out = out_free & ~pix_held;
			default: ready_out = 1'b0;
		endcase
	end

	// Payload beat beat_cnt of the control packet.
	always_comb begin
		int n;
		ctrl_beat = '0;
		for (int s = 0; s < SYMBOLS_PER_BEAT; s++) begin
			n = int'(beat_cnt) * SYMBOLS_PER_BEAT + s;
			if (n < nibbles) begin
				ctrl_beat[s*BITS_PER_SYMBOL +: 4] = ctrl_q[(nibbles-1-n)*4 +: 4];
			end
		end
	end

	always_comb begin
		load = 1'b0;
		load_data = pix_q;
		load_sop = 1'b0;
		load_eop = 1'b0;
		case (state)
			st_ctrl_hdr: begin
				load = out_free;
				load_data = hdr_ctrl;
				load_sop = 1'b1;
			end
			st_ctrl_pay: begin
				load = out_free;
				load_data = ctrl_beat;
				load_eop = beat_cnt == cnt_w'(ctrl_beats - 1);
			end
			st_vid_hdr: begin
				load = out_free;
				load_data = hdr_video;
				load_sop = 1'b1;
			end
			st_vid_body: begin
				if (pix_held) begin
					load = out_free;
					load_eop = pix_eov;
				end else begin
					load = take_in;
					load_data = beat_in;
					load_eop = dout_end_of_video;
				end
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// FSM and output register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= st_idle;
			beat_cnt <= '0;
			pix_held <= 1'b0;
			dout_valid <= 1'b0;
		end else begin
			if (load) begin
				dout_valid <= 1'b1;
			end else if (dout_ready) begin
				dout_valid <= 1'b0;
			end
			case (state)
				st_idle: begin
					if (take_in) begin
						pix_held <= 1'b1;
					end
					// A pending control packet goes before a held pixel.
					if (ctrl_send) begin
						state <= st_ctrl_hdr;
					end else if (!dout_valid && (pix_held || take_in)) begin
						state <= st_vid_hdr;
					end
				end
				st_ctrl_hdr: begin
					if (load) begin
						beat_cnt <= '0;
						state <= st_ctrl_pay;
					end
				end
				st_ctrl_pay: begin
					if (load) begin
						beat_cnt <= beat_cnt + 1'b1;
						if (load_eop) begin
							state <= pix_held ? st_vid_hdr : st_idle;
						end
					end
				end
				st_vid_hdr: begin
					if (load) begin
						state <= st_vid_body;
					end
				end
				st_vid_body: begin
					if (load) begin
						pix_held <= 1'b0;
						if (load_eop) begin
							state <= st_idle;
						end
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && ctrl_send) begin
			ctrl_q <= enc_ctrl;
		end
		if (state == st_idle && take_in) begin
			pix_q <= beat_in;
			pix_eov <= dout_end_of_video;
		end
		if (load) begin
			dout_data <= load_data;
			dout_sop <= load_sop;
			dout_eop <= load_eop;
		end
	end

	a_hold_under_backpressure: assert property (@(posedge clk) disable iff (rst)
		dout_valid && !dout_ready |=> dout_valid && $stable(dout_data));

endmodule

//--- vip_swap_top.sv
`timescale 1ns/1ns

module vip_swap_top (
	input logic clk,
	input logic rst,
	input logic din_valid,
	output logic din_ready,
	input vip_stream_pkg::beat_t din_data,
	input logic din_sop,
	input logic din_eop,
	output logic dout_valid,
	input logic dout_ready,
	output vip_stream_pkg::beat_t dout_data,
	output logic dout_sop,
	output logic dout_eop
);

	localparam int beat_w = vip_stream_pkg::bits_per_symbol * vip_stream_pkg::symbols_per_beat;

	logic fco_valid;
	logic fco_eov;
	logic [beat_w-1:0] fco_data;
	logic enc_ready;
	logic ctrl_send;
	logic ctrl_busy;
	vip_ctrl_pkg::ctrl_fields_t enc_ctrl;

	vip_core_if #(.BEAT_W(beat_w)) core_in ();
	vip_core_if #(.BEAT_W(beat_w)) core_out ();

	vip_packet_decoder decoder0 (
		.clk(clk),
		.rst(rst),
		.din_valid(din_valid),
		.din_sop(din_sop),
		.din_eop(din_eop),
		.din_data(din_data),
		.din_ready(din_ready),
		.core(core_in.source)
	);

	vip_symbol_swap_core #(
		.BITS_PER_SYMBOL(vip_stream_pkg::bits_per_symbol),
		.SYMBOLS_PER_BEAT(vip_stream_pkg::symbols_per_beat)
	) core0 (
		.clk(clk),
		.rst(rst),
		.core_in(core_in.sink),
		.core_out(core_out.source)
	);

	vip_flow_control_output #(
		.BITS_PER_SYMBOL(vip_stream_pkg::bits_per_symbol),
		.SYMBOLS_PER_BEAT(vip_stream_pkg::symbols_per_beat),
		.WIDTH_DEFAULT(vip_stream_pkg::width_default),
		.HEIGHT_DEFAULT(vip_stream_pkg::height_default),
		.INTERLACED_DEFAULT(vip_stream_pkg::interlaced_default)
	) fco0 (
		.clk(clk),
		.rst(rst),
		.core(core_out.sink),
		.dout_ready(enc_ready),
		.ctrl_busy(ctrl_busy),
		.dout_valid(fco_valid),
		.dout_end_of_video(fco_eov),
		.dout_data(fco_data),
		.ctrl_send(ctrl_send),
		.enc_ctrl(enc_ctrl)
	);

	vip_packet_encoder #(
		.BITS_PER_SYMBOL(vip_stream_pkg::bits_per_symbol),
		.SYMBOLS_PER_BEAT(vip_stream_pkg::symbols_per_beat)
	) encoder0 (
		.clk(clk),
		.rst(rst),
		.dout_valid_in(fco_valid),
		.dout_end_of_video(fco_eov),
		.ctrl_send(ctrl_send),
		.beat_in(fco_data),
		.enc_ctrl(enc_ctrl),
		.ctrl_busy(ctrl_busy),
		.ready_out(enc_ready),
		.dout_valid(dout_valid),
		.dout_sop(dout_sop),
		.dout_eop(dout_eop),
		.dout_data(dout_data),
		.dout_ready(dout_ready)
	);

endmodule

//--- tb_vip_swap.sv
`timescale 1ns/1ns

module tb_vip_swap;

	typedef struct packed {
		logic send_ctrl;
		logic [15:0] width;
		logic [15:0] height;
		logic [3:0] interlaced;
		logic [7:0] pix_beats;
		logic junk_first;
	} frame_row_t;

	localparam int num_rows = 9;
	localparam int num_passes = 2;

	logic clk;
	logic rst;
	logic din_valid;
	logic din_ready;
	vip_stream_pkg::beat_t din_data;
	logic din_sop;
	logic din_eop;
	logic dout_valid;
	logic dout_ready;
	vip_stream_pkg::beat_t dout_data;
	logic dout_sop;
	logic dout_eop;

	frame_row_t frame_table [num_rows];
	logic [25:0] exp_q [$];
	logic [15:0] lfsr;
	logic use_gaps;
	logic ready_next;
	int value_errs;
	int other_errs;
	int beats_checked;
	int cycle_cnt;
	int timeout_limit = 1000000;

	vip_swap_top dut0 (
		.clk(clk),
		.rst(rst),
		.din_valid(din_valid),
		.din_ready(din_ready),
		.din_data(din_data),
		.din_sop(din_sop),
		.din_eop(din_eop),
		.dout_valid(dout_valid),
		.dout_ready(dout_ready),
		.dout_data(dout_data),
		.dout_sop(dout_sop),
		.dout_eop(dout_eop)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Frame table and helpers
	////////////////////////////////////////////////////////////

	// Columns: send control, width, height, interlaced, pixel beats, junk first.
	task automatic load_table();
		frame_table[0] = '{1'b1, 16'd320, 16'd240, 4'h0, 8'd6, 1'b0};
		frame_table[1] = '{1'b0, 16'd0, 16'd0, 4'h0, 8'd4, 1'b0};
		// Control only, so the next row sends a second control packet right after.
		frame_table[2] = '{1'b1, 16'd1920, 16'd1080, 4'h3, 8'd0, 1'b1};
		frame_table[3] = '{1'b1, 16'h1234, 16'habcd, 4'h9, 8'd5, 1'b0};
		frame_table[4] = '{1'b0, 16'd0, 16'd0, 4'h0, 8'd1, 1'b1};
		frame_table[5] = '{1'b1, 16'hffff, 16'h0001, 4'hf, 8'd3, 1'b0};
		frame_table[6] = '{1'b0, 16'd0, 16'd0, 4'h0, 8'd8, 1'b1};
		frame_table[7] = '{1'b0, 16'd0, 16'd0, 4'h0, 8'd0, 1'b1};
		frame_table[8] = '{1'b1, 16'h0500, 16'h02d0, 4'h1, 8'd2, 1'b0};
	endtask

	// Input beats over all passes.
	function automatic int count_beats();
		int total;
		total = 0;
		for (int r = 0; r < num_rows; r++) begin
			total += frame_table[r].send_ctrl ? 4 : 0;
			total += frame_table[r].junk_first ? 3 : 0;
			total += (frame_table[r].pix_beats != 0) ? int'(frame_table[r].pix_beats) + 1 : 0;
		end
		return total * num_passes;
	endfunction

	// Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] want);
		if (got !== want) begin
			value_errs++;
			$display("ERR %0t: %s mismatch, got %h expected %h", $time, what, got, want);
		end
	endtask

	task automatic expect_beat(input vip_stream_pkg::beat_t d, input logic sop, input logic eop);
		exp_q.push_back({sop, eop, d});
	endtask

	// One input beat, held until the DUT takes it.
	task automatic drive_beat(input vip_stream_pkg::beat_t d, input logic sop, input logic eop);
		while (use_gaps && rand_bits(2) == 0) begin
			din_valid = 1'b0;
			@(posedge clk);
			#1;
		end
		din_valid = 1'b1;
		din_data = d;
		din_sop = sop;
		din_eop = eop;
		@(negedge clk);
		while (!din_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		din_valid = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Packet sources with their expected output
	////////////////////////////////////////////////////////////

	task automatic send_ctrl_packet(input logic [15:0] w, input logic [15:0] h,
			input logic [3:0] il);
		logic [3:0] nib [9];
		logic [31:0] rnd;
		vip_stream_pkg::beat_t in_beat;
		vip_stream_pkg::beat_t out_beat;
		nib[0] = w[15:12];
		nib[1] = w[11:8];
		nib[2] = w[7:4];
		nib[3] = w[3:0];
		nib[4] = h[15:12];
		nib[5] = h[11:8];
		nib[6] = h[7:4];
		nib[7] = h[3:0];
		nib[8] = il;
		out_beat = '0;
		out_beat[0][3:0] = vip_stream_pkg::type_ctrl;
		expect_beat(out_beat, 1'b1, 1'b0);
		for (int b = 0; b < 3; b++) begin
			out_beat = '0;
			for (int s = 0; s < 3; s++) begin
				out_beat[s][3:0] = nib[3*b+s];
			end
			expect_beat(out_beat, 1'b0, b == 2);
		end
		// Upper nibbles on the input are don't care.
		rnd = rand_bits(24);
		in_beat = rnd[23:0];
		in_beat[0][3:0] = vip_stream_pkg::type_ctrl;
		drive_beat(in_beat, 1'b1, 1'b0);
		for (int b = 0; b < 3; b++) begin
			rnd = rand_bits(24);
			in_beat = rnd[23:0];
			for (int s = 0; s < 3; s++) begin
				in_beat[s][3:0] = nib[3*b+s];
			end
			drive_beat(in_beat, 1'b0, b == 2);
		end
	endtask

	task automatic send_video_packet(input int n);
		logic [31:0] rnd;
		vip_stream_pkg::beat_t in_beat;
		vip_stream_pkg::beat_t out_beat;
		rnd = rand_bits(24);
		in_beat = rnd[23:0];
		in_beat[0][3:0] = vip_stream_pkg::type_video;
		expect_beat('0, 1'b1, 1'b0);
		drive_beat(in_beat, 1'b1, 1'b0);
		for (int i = 0; i < n; i++) begin
			rnd = rand_bits(24);
			in_beat = rnd[23:0];
			// Symbol 0 comes out as the last symbol.
			out_beat = {in_beat[0], in_beat[1], in_beat[2]};
			expect_beat(out_beat, 1'b0, i == n - 1);
			drive_beat(in_beat, 1'b0, i == n - 1);
		end
	endtask

	// Type 5 is unknown to the decoder, so nothing is expected.
	task automatic inject_junk();
		logic [31:0] rnd;
		vip_stream_pkg::beat_t in_beat;
		for (int i = 0; i < 3; i++) begin
			rnd = rand_bits(24);
			in_beat = rnd[23:0];
			if (i == 0) begin
				in_beat[0][3:0] = 4'd5;
			end
			drive_beat(in_beat, i == 0, i == 2);
		end
	endtask

	task automatic apply_row(input frame_row_t row);
		if (row.junk_first) begin
			inject_junk();
		end
		if (row.send_ctrl) begin
			send_ctrl_packet(row.width, row.height, row.interlaced);
		end
		if (row.pix_beats != 0) begin
			send_video_packet(int'(row.pix_beats));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Output sink
	////////////////////////////////////////////////////////////

	task automatic check_output();
		logic [25:0] exp;
		if (exp_q.size() == 0) begin
			other_errs++;
			$display("Output beat %h at %0t arrived while no packet was expected",
				dout_data, $time);
		end else begin
			exp = exp_q.pop_front();
			check_value("dout_sop", 32'(dout_sop), 32'(exp[25]));
			check_value("dout_eop", 32'(dout_eop), 32'(exp[24]));
			check_value("dout_data", 32'(dout_data), 32'(exp[23:0]));
			beats_checked++;
		end
	endtask

	// Outputs are stable at the falling edge.
	always @(negedge clk) begin
		if (!rst) begin
			if (dout_valid && dout_ready) begin
				check_output();
			end
			ready_next = !(use_gaps && rand_bits(2) == 0);
		end
	end

	always @(posedge clk) begin
		#1;
		dout_ready = ready_next;
	end

	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			$display("Timeout after %0d cycles, %0d output beats never arrived",
				cycle_cnt, exp_q.size());
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		din_valid = 1'b0;
		din_data = '0;
		din_sop = 1'b0;
		din_eop = 1'b0;
		dout_ready = 1'b0;
		ready_next = 1'b1;
		use_gaps = 1'b0;
		lfsr = 16'd7;
		value_errs = 0;
		other_errs = 0;
		beats_checked = 0;
		cycle_cnt = 0;
		load_table();
		timeout_limit = count_beats() * 8 + 200;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		// First pass runs at full rate, the second with random gaps.
		for (int pass = 0; pass < num_passes; pass++) begin
			use_gaps = (pass == 1);
			for (int r = 0; r < num_rows; r++) begin
				apply_row(frame_table[r]);
			end
		end
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		// Give stray beats a chance to show up.
		repeat (20) @(posedge clk);
		$display("Done: %0d beats checked, %0d value errors, %0d other errors",
			beats_checked, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- tb.f
vip_stream_pkg.sv
vip_ctrl_pkg.sv
vip_core_if.sv
vip_packet_decoder.sv
vip_symbol_swap_core.sv
vip_flow_control_output.sv
vip_packet_encoder.sv
vip_swap_top.sv
tb_vip_swap.sv

//--- Bender.yml
package:
  name: vip_swap

sources:
  - vip_stream_pkg.sv
  - vip_ctrl_pkg.sv
  - vip_core_if.sv
  - vip_packet_decoder.sv
  - vip_symbol_swap_core.sv
  - vip_flow_control_output.sv
  - vip_packet_encoder.sv
  - vip_swap_top.sv
  - target: test
    files:
      - tb_vip_swap.sv
